/* bp_unit.f */
+incdir+include
source/bp_pkg.sv
source/bp_table_ram.sv
source/bp_predictor.sv
source/bp_sweep_fsm.sv
source/bp_stat_counters.sv
source/bp_wb_regs.sv
source/bp_unit.sv
verif/bp_unit_tb.sv

/* include/bp_macros.svh */
`ifndef BP_MACROS_SVH
`define BP_MACROS_SVH

// table geometry, 256 entries of 2-bit counters
`define BP_INDEX_BITS  8
`define BP_HISTORY_LEN 8
// lowest pc bit used for the index
`define BP_PC_LSB      2

// register word offsets on the wishbone port
`define BP_REG_CTRL    2'd0
`define BP_REG_STATUS  2'd1
`define BP_REG_UPDATES 2'd2
`define BP_REG_MISSES  2'd3

`define BP_STAT_BITS   32

`endif

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary -j 0 --top-module bp_unit_tb -f bp_unit.f -o bp_unit_sim

# $fatal gives a nonzero exit, so the log is searched instead
./obj_dir/bp_unit_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Verification failed" sim.log; then
    echo "testbench reported an error"
    exit 1
fi
if ! grep -q "Verification passed" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "run complete"

/* source/bp_pkg.sv */
package bp_pkg;

    // 2-bit saturating counter, upper bit is the taken prediction
    typedef enum logic [1:0] {
        strongly_untaken = 2'd0,
        weakly_untaken   = 2'd1,
        weakly_taken     = 2'd2,
        strongly_taken   = 2'd3
    } bp_counter_t;

    // table initialization sequencer
    typedef enum logic [1:0] {
        sweep_idle  = 2'd0,
        sweep_fill  = 2'd1,
        sweep_ready = 2'd2
    } bp_sweep_state_t;

endpackage

/* source/bp_predictor.sv */
`include "bp_macros.svh"

module bp_predictor (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic [31:0]               pc,
    input  logic                      mode,
    input  logic                      sweep_start,
    input  logic                      update,
    input  logic [`BP_INDEX_BITS-1:0] update_index,
    input  bp_pkg::bp_counter_t       update_counter,
    input  logic                      actual,
    input  bp_pkg::bp_counter_t       rdata,
    output logic [`BP_INDEX_BITS-1:0] raddr,
    output logic [`BP_INDEX_BITS-1:0] pred_index,
    output bp_pkg::bp_counter_t       pred_counter,
    output logic                      pred,
    output logic                      upd_we,
    output logic [`BP_INDEX_BITS-1:0] upd_addr,
    output bp_pkg::bp_counter_t       upd_data
);

    logic [`BP_HISTORY_LEN-1:0] history;
    logic [`BP_INDEX_BITS-1:0]  pc_bits;

    assign pc_bits = pc[`BP_PC_LSB +: `BP_INDEX_BITS];

    // gshare folds the global history into the index, bimodal uses pc only
    assign raddr = mode ? (pc_bits ^ history) : pc_bits;

    // ram output lines up with the registered index
    assign pred_counter = rdata;
    assign pred         = rdata[1];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            pred_index <= '0;
            history    <= '0;
        end else begin
            pred_index <= raddr;
            if (sweep_start) begin
                history <= '0;
            end else if (update && mode) begin
                // newest outcome enters at the low end
                history <= {history[`BP_HISTORY_LEN-2:0], actual};
            end
        end
    end

    assign upd_we   = update;
    assign upd_addr = update_index;

    // saturating step toward the resolved outcome
    always_comb begin
        case (update_counter)
            bp_pkg::strongly_untaken:
                upd_data = actual ? bp_pkg::weakly_untaken : bp_pkg::strongly_untaken;
            bp_pkg::weakly_untaken:
                upd_data = actual ? bp_pkg::weakly_taken : bp_pkg::strongly_untaken;
            bp_pkg::weakly_taken:
                upd_data = actual ? bp_pkg::strongly_taken : bp_pkg::weakly_untaken;
            bp_pkg::strongly_taken:
                upd_data = actual ? bp_pkg::strongly_taken : bp_pkg::weakly_taken;
            default:
                upd_data = bp_pkg::weakly_untaken;
        endcase
    end

endmodule

/* source/bp_stat_counters.sv */
`include "bp_macros.svh"

module bp_stat_counters (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     clear,
    input  logic                     count_en,
    input  bp_pkg::bp_counter_t      update_counter,
    input  logic                     actual,
    output logic [`BP_STAT_BITS-1:0] updates,
    output logic [`BP_STAT_BITS-1:0] misses
);

    logic miss;

    // the prediction made was the counter's upper bit
    assign miss = (update_counter[1] != actual);

    always_ff @(posedge clk) begin
        if (!rstn || clear) begin
            updates <= '0;
            misses  <= '0;
        end else if (count_en) begin
            // both counters stick at all ones
            if (updates != '1) begin
                updates <= updates + 1'b1;
            end
            if (miss && misses != '1) begin
                misses <= misses + 1'b1;
            end
        end
    end

endmodule

/* source/bp_sweep_fsm.sv */
`include "bp_macros.svh"

module bp_sweep_fsm (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      flush,
    input  logic                      upd_we,
    input  logic [`BP_INDEX_BITS-1:0] upd_addr,
    input  bp_pkg::bp_counter_t       upd_data,
    output logic                      we,
    output logic [`BP_INDEX_BITS-1:0] waddr,
    output bp_pkg::bp_counter_t       wdata,
    output logic                      ready,
    output logic                      sweep_start
);

    bp_pkg::bp_sweep_state_t   state;
    logic [`BP_INDEX_BITS-1:0] fill_addr;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state       <= bp_pkg::sweep_idle;
            fill_addr   <= '0;
            sweep_start <= 1'b0;
        end else begin
            sweep_start <= 1'b0;
            if (flush) begin
                // restart the fill from the bottom of the table
                state       <= bp_pkg::sweep_fill;
                fill_addr   <= '0;
                sweep_start <= 1'b1;
            end else begin
                case (state)
                    bp_pkg::sweep_idle: begin
                        state       <= bp_pkg::sweep_fill;
                        fill_addr   <= '0;
                        sweep_start <= 1'b1;
                    end
                    bp_pkg::sweep_fill: begin
                        fill_addr <= fill_addr + 1'b1;
                        if (fill_addr == '1) begin
                            state <= bp_pkg::sweep_ready;
                        end
                    end
                    bp_pkg::sweep_ready: begin
                        state <= bp_pkg::sweep_ready;
                    end
                    default: begin
                        state <= bp_pkg::sweep_idle;
                    end
                endcase
            end
        end
    end

    assign ready = (state == bp_pkg::sweep_ready);

    // fill owns the write port, otherwise updates pass once ready
    always_comb begin
        if (state == bp_pkg::sweep_fill) begin
            we    = 1'b1;
            waddr = fill_addr;
            wdata = bp_pkg::weakly_untaken;
        end else begin
            we    = upd_we && ready;
            waddr = upd_addr;
            wdata = upd_data;
        end
    end

endmodule

/* source/bp_table_ram.sv */
`include "bp_macros.svh"

module bp_table_ram (
    input  logic                      clk,
    input  logic                      we,
    input  logic [`BP_INDEX_BITS-1:0] waddr,
    input  bp_pkg::bp_counter_t       wdata,
    input  logic [`BP_INDEX_BITS-1:0] raddr,
    output bp_pkg::bp_counter_t       rdata
);

    bp_pkg::bp_counter_t mem [1 << `BP_INDEX_BITS];

    // read-first, a same-cycle write is seen on the next read
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

endmodule

/* source/bp_unit.sv */
`include "bp_macros.svh"

module bp_unit (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic [31:0]               pc,
    input  logic                      update,
    input  logic [`BP_INDEX_BITS-1:0] update_index,
    input  bp_pkg::bp_counter_t       update_counter,
    input  logic                      actual,
    input  logic                      cyc,
    input  logic                      stb,
    input  logic                      we,
    input  logic [1:0]                adr,
    input  logic [31:0]               dat_w,
    output logic [`BP_INDEX_BITS-1:0] pred_index,
    output bp_pkg::bp_counter_t       pred_counter,
    output logic                      pred,
    output logic                      ready,
    output logic [31:0]               dat_r,
    output logic                      ack
);

    logic                      mode;
    logic                      flush;
    logic                      clear;
    logic                      sweep_start;
    logic [`BP_INDEX_BITS-1:0] raddr;
    bp_pkg::bp_counter_t       rdata;
    logic                      upd_we;
    logic [`BP_INDEX_BITS-1:0] upd_addr;
    bp_pkg::bp_counter_t       upd_data;
    logic                      ram_we;
    logic [`BP_INDEX_BITS-1:0] ram_waddr;
    bp_pkg::bp_counter_t       ram_wdata;
    logic [`BP_STAT_BITS-1:0]  updates;
    logic [`BP_STAT_BITS-1:0]  misses;

    bp_predictor u_predictor (
        .clk(clk), .rstn(rstn), .pc(pc), .mode(mode), .sweep_start(sweep_start),
        .update(update), .update_index(update_index), .update_counter(update_counter),
        .actual(actual), .rdata(rdata), .raddr(raddr), .pred_index(pred_index),
        .pred_counter(pred_counter), .pred(pred), .upd_we(upd_we),
        .upd_addr(upd_addr), .upd_data(upd_data)
    );

    bp_table_ram u_table (
        .clk(clk), .we(ram_we), .waddr(ram_waddr), .wdata(ram_wdata),
        .raddr(raddr), .rdata(rdata)
    );

    bp_sweep_fsm u_sweep (
        .clk(clk), .rstn(rstn), .flush(flush), .upd_we(upd_we), .upd_addr(upd_addr),
        .upd_data(upd_data), .we(ram_we), .waddr(ram_waddr), .wdata(ram_wdata),
        .ready(ready), .sweep_start(sweep_start)
    );

    // only updates seen while ready are counted
    bp_stat_counters u_stats (
        .clk(clk), .rstn(rstn), .clear(clear), .count_en(ready & update),
        .update_counter(update_counter), .actual(actual),
        .updates(updates), .misses(misses)
    );

    bp_wb_regs u_regs (
        .clk(clk), .rstn(rstn), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .dat_w(dat_w), .ready(ready), .updates(updates), .misses(misses),
        .dat_r(dat_r), .ack(ack), .mode(mode), .flush(flush), .clear(clear)
    );

endmodule

/* source/bp_wb_regs.sv */
`include "bp_macros.svh"

module bp_wb_regs (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     cyc,
    input  logic                     stb,
    input  logic                     we,
    input  logic [1:0]               adr,
    input  logic [31:0]              dat_w,
    input  logic                     ready,
    input  logic [`BP_STAT_BITS-1:0] updates,
    input  logic [`BP_STAT_BITS-1:0] misses,
    output logic [31:0]              dat_r,
    output logic                     ack,
    output logic                     mode,
    output logic                     flush,
    output logic                     clear
);

    logic req;

    // new request, the master holds it until ack
    assign req = cyc && stb && !ack;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            ack   <= 1'b0;
            mode  <= 1'b0;
            flush <= 1'b0;
            clear <= 1'b0;
        end else begin
            ack   <= req;
            flush <= 1'b0;
            clear <= 1'b0;
            if (req && we && adr == `BP_REG_CTRL) begin
                mode  <= dat_w[0];
                // bits 1 and 2 are strobes, not stored
                flush <= dat_w[1];
                clear <= dat_w[2];
            end
        end
    end

    // read data is captured together with ack
    always_ff @(posedge clk) begin
        if (req) begin
            case (adr)
                `BP_REG_CTRL:    dat_r <= {31'd0, mode};
                `BP_REG_STATUS:  dat_r <= {31'd0, ready};
                `BP_REG_UPDATES: dat_r <= updates;
                `BP_REG_MISSES:  dat_r <= misses;
                default:         dat_r <= '0;
            endcase
        end
    end

endmodule

/* verif/bp_unit_tb.sv */
`include "bp_macros.svh"

module bp_unit_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int WAIT_LIMIT = 1000;
    localparam int TABLE_SIZE = 1 << `BP_INDEX_BITS;

    logic                       clk;
    logic                       rstn;
    logic [31:0]                pc;
    logic                       update;
    logic [`BP_INDEX_BITS-1:0]  update_index;
    bp_pkg::bp_counter_t        update_counter;
    logic                       actual;
    logic                       cyc;
    logic                       stb;
    logic                       we;
    logic [1:0]                 adr;
    logic [31:0]                dat_w;
    logic [`BP_INDEX_BITS-1:0]  pred_index;
    bp_pkg::bp_counter_t        pred_counter;
    logic                       pred;
    logic                       ready;
    logic [31:0]                dat_r;
    logic                       ack;

    // reference model of the counter table and history
    logic [1:0]                 model_table [TABLE_SIZE];
    logic [`BP_HISTORY_LEN-1:0] model_history;
    logic                       model_mode;
    logic [31:0]                model_updates;
    logic [31:0]                model_misses;
    logic [31:0]                lfsr;

    // stimulus table with one entry per row in each queue
    string                      row_name [$];
    logic [31:0]                row_pc [$];
    logic                       row_actual [$];

    bp_unit u_dut (
        .clk(clk), .rstn(rstn), .pc(pc), .update(update), .update_index(update_index),
        .update_counter(update_counter), .actual(actual), .cyc(cyc), .stb(stb),
        .we(we), .adr(adr), .dat_w(dat_w), .pred_index(pred_index),
        .pred_counter(pred_counter), .pred(pred), .ready(ready), .dat_r(dat_r),
        .ack(ack)
    );

    always #2 clk = ~clk;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] got);
        if (expected !== got) begin
            $display("MISMATCH %s expected 0x%0h actual 0x%0h", name, expected, got);
            fail_run("value check failed");
        end
    endtask

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    task automatic random_pc(output logic [31:0] value);
        value = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr  = lfsr_next(lfsr);
            value = {value[30:0], lfsr[0]};
        end
    endtask

    // 2-bit saturating step toward the outcome
    function automatic logic [1:0] next_counter(input logic [1:0] count, input logic taken);
        if (taken) begin
            return (count == 2'd3) ? 2'd3 : count + 2'd1;
        end
        return (count == 2'd0) ? 2'd0 : count - 2'd1;
    endfunction

    function automatic logic [`BP_INDEX_BITS-1:0] expected_index(input logic [31:0] addr);
        logic [`BP_INDEX_BITS-1:0] bits;
        bits = addr[`BP_PC_LSB +: `BP_INDEX_BITS];
        return model_mode ? (bits ^ model_history) : bits;
    endfunction

    // every entry back to weakly untaken
    task automatic clear_model();
        for (int i = 0; i < TABLE_SIZE; i++) begin
            model_table[i] = 2'd1;
        end
        model_history = '0;
    endtask

    task automatic add_row(input string name, input logic [31:0] addr, input logic taken);
        row_name.push_back(name);
        row_pc.push_back(addr);
        row_actual.push_back(taken);
    endtask

    // prediction is valid one cycle after pc
    task automatic predict_and_check(input string name, input logic [31:0] addr);
        logic [`BP_INDEX_BITS-1:0] idx;
        idx = expected_index(addr);
        pc  = addr;
        @(negedge clk);
        compare({name, " index"}, 32'(idx), 32'(pred_index));
        compare({name, " counter"}, 32'(model_table[idx]), 32'(pred_counter));
        compare({name, " pred"}, 32'(model_table[idx][1]), 32'(pred));
    endtask

    // return the index and counter of the last prediction with its outcome
    task automatic train(input logic taken);
        logic [1:0]                count;
        logic [`BP_INDEX_BITS-1:0] idx;
        count          = pred_counter;
        idx            = pred_index;
        update         = 1'b1;
        update_index   = pred_index;
        update_counter = pred_counter;
        actual         = taken;
        @(negedge clk);
        update = 1'b0;
        model_table[idx] = next_counter(count, taken);
        if (model_mode) begin
            model_history = {model_history[`BP_HISTORY_LEN-2:0], taken};
        end
        model_updates = model_updates + 32'd1;
        if (count[1] != taken) begin
            model_misses = model_misses + 32'd1;
        end
    endtask

    task automatic apply_rows(input int first, input int last);
        for (int r = first; r < last; r++) begin
            predict_and_check(row_name[r], row_pc[r]);
            train(row_actual[r]);
        end
    endtask

    // predicts every table pc again, all of them trained before the flush
    task automatic check_trained_pcs(input string name);
        for (int r = 0; r < row_name.size(); r++) begin
            predict_and_check(name, row_pc[r]);
        end
    endtask

    task automatic wb_write(input logic [1:0] addr, input logic [31:0] data);
        int count;
        count = 0;
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = 1'b1;
        adr   = addr;
        dat_w = data;
        while (!ack && count < WAIT_LIMIT) begin
            @(negedge clk);
            count++;
        end
        if (!ack) begin
            fail_run("register write was never acknowledged");
        end
        // one wait state before ack
        compare("wb_write_ack_delay", 32'd1, 32'(count));
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
        // idle cycle lets ack fall and the strobes take effect
        @(negedge clk);
        compare("wb_write_ack_drop", 32'd0, 32'(ack));
    endtask

    task automatic wb_read(input logic [1:0] addr, output logic [31:0] data);
        int count;
        count = 0;
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = 1'b0;
        adr   = addr;
        while (!ack && count < WAIT_LIMIT) begin
            @(negedge clk);
            count++;
        end
        if (!ack) begin
            fail_run("register read was never acknowledged");
        end
        compare("wb_read_ack_delay", 32'd1, 32'(count));
        data = dat_r;
        cyc  = 1'b0;
        stb  = 1'b0;
        @(negedge clk);
        compare("wb_read_ack_drop", 32'd0, 32'(ack));
    endtask

    task automatic wait_for_ready();
        int count;
        count = 0;
        while (!ready && count < WAIT_LIMIT) begin
            @(negedge clk);
            count++;
        end
        if (!ready) begin
            fail_run("ready did not rise after the table sweep");
        end
    endtask

    initial begin
        logic [31:0] data;
        logic [31:0] addr;
        int          bimodal_rows;
        clk            = 1'b0;
        rstn           = 1'b0;
        pc             = '0;
        update         = 1'b0;
        update_index   = '0;
        update_counter = bp_pkg::strongly_untaken;
        actual         = 1'b0;
        cyc            = 1'b0;
        stb            = 1'b0;
        we             = 1'b0;
        adr            = '0;
        dat_w          = '0;
        lfsr           = 32'h5dea0301;
        model_mode     = 1'b0;
        model_updates  = '0;
        model_misses   = '0;
        clear_model();

        // saturate up, walk back down, then a second pc
        for (int i = 0; i < 4; i++) begin
            add_row("bimodal_up", 32'h0000_0100, 1'b1);
        end
        for (int i = 0; i < 4; i++) begin
            add_row("bimodal_down", 32'h0000_0100, 1'b0);
        end
        add_row("bimodal_other", 32'h0000_0a44, 1'b1);
        add_row("bimodal_other", 32'h0000_0a44, 1'b0);
        bimodal_rows = row_name.size();
        for (int i = 0; i < 8; i++) begin
            add_row("gshare_alt", 32'h0000_0200, (i % 2) == 1);
        end
        for (int i = 0; i < 4; i++) begin
            add_row("gshare_mix", 32'h0000_3c48, 1'b1);
        end

        repeat (10) @(negedge clk);
        rstn = 1'b1;

        wait_for_ready();
        for (int i = 0; i < 8; i++) begin
            random_pc(addr);
            predict_and_check("reset_fill", addr);
        end
        wb_read(`BP_REG_STATUS, data);
        compare("status_ready", 32'd1, data);

        apply_rows(0, bimodal_rows);

        wb_write(`BP_REG_CTRL, 32'd1);
        model_mode = 1'b1;
        wb_read(`BP_REG_CTRL, data);
        compare("ctrl_mode", 32'd1, data);
        apply_rows(bimodal_rows, row_name.size());

        wb_read(`BP_REG_UPDATES, data);
        compare("stat_updates", model_updates, data);
        wb_read(`BP_REG_MISSES, data);
        compare("stat_misses", model_misses, data);
        // clear with gshare kept
        wb_write(`BP_REG_CTRL, 32'h5);
        model_updates = '0;
        model_misses  = '0;
        wb_read(`BP_REG_UPDATES, data);
        compare("stat_updates_clear", model_updates, data);
        wb_read(`BP_REG_MISSES, data);
        compare("stat_misses_clear", model_misses, data);

        wb_write(`BP_REG_CTRL, 32'h3);
        compare("flush_ready_low", 32'd0, 32'(ready));
        wait_for_ready();
        clear_model();
        for (int i = 0; i < 8; i++) begin
            random_pc(addr);
            predict_and_check("flush_gshare", addr);
        end
        check_trained_pcs("flush_trained_gshare");
        wb_write(`BP_REG_CTRL, 32'd0);
        model_mode = 1'b0;
        for (int i = 0; i < 8; i++) begin
            random_pc(addr);
            predict_and_check("flush_bimodal", addr);
        end
        check_trained_pcs("flush_trained_bimodal");

        $display("Verification passed");
        $finish;
    end

endmodule
